//--- dcache.f
verilog/cache_pkg.sv
verilog/mem_bus_pkg.sv
verilog/sync_ram.sv
verilog/refill_counter.sv
verilog/lookup_datapath.sv
verilog/cache_ctrl_fsm.sv
verilog/dcache_top.sv
verif/clk_gen.sv
verif/tb_dcache.sv

//--- verif/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
  output logic clk_o,
  output logic resetn_o
);

  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;  // 40 ns period
  end

  initial begin
    resetn_o = 1'b0;
    repeat (5) @(posedge clk_o);
    resetn_o <= 1'b1;
  end

endmodule

//--- verif/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;

  import cache_pkg::*;
  import mem_bus_pkg::*;

  localparam int TIMEOUT = 200;  // cycles without progress

  logic        clk;
  logic        resetn;
  logic        valid;
  cpu_req_t    req;
  logic        addr_ok;
  logic        data_ok;
  word_t       rdata;
  logic        rd_req;
  mem_rd_req_t rd;
  logic        rd_rdy;
  logic        ret_valid;
  mem_ret_t    ret;
  logic        wr_req;
  mem_wr_req_t wr;
  logic        wr_rdy;

  integer seed;
  int     cycle;
  int     err_cnt;
  int     check_cnt;
  int     test_cnt;
  int     rd_cnt;
  int     wb_cnt;

  word_t    model_mem [word_t];  // latest value of every touched word
  word_t    img_mem [word_t];    // memory image after write-backs
  bit       dirty_tb [word_t];   // lines stored to since last fetch
  cpu_req_t stim_q [$];
  bit       fast_q [$];
  word_t    pend_addr [$];
  logic     pend_op [$];
  word_t    pend_exp [$];
  int       pend_cyc [$];
  bit       pend_fast [$];

  tag_t   tag_pool [6] = '{20'h00001, 20'h00002, 20'h0abcd, 20'h12345, 20'h7ffff, 20'h00f00};
  index_t idx_pool [3] = '{8'h10, 8'h21, 8'h3f};

  clk_gen u_clk_gen (
    .clk_o    (clk),
    .resetn_o (resetn)
  );

  dcache_top dut_i (
    .clk         (clk),
    .resetn      (resetn),
    .valid_i     (valid),
    .req_i       (req),
    .addr_ok_o   (addr_ok),
    .data_ok_o   (data_ok),
    .rdata_o     (rdata),
    .rd_req_o    (rd_req),
    .rd_o        (rd),
    .rd_rdy_i    (rd_rdy),
    .ret_valid_i (ret_valid),
    .ret_i       (ret),
    .wr_req_o    (wr_req),
    .wr_o        (wr),
    .wr_rdy_i    (wr_rdy)
  );

  // untouched memory pattern over every address bit
  function automatic word_t fill_word(word_t a);
    return a ^ {a[15:0], a[31:16]} ^ 32'h5a3c_96e1;
  endfunction

  function automatic word_t img_word(word_t a);
    return img_mem.exists(a) ? img_mem[a] : fill_word(a);
  endfunction

  function automatic word_t model_word(word_t a);
    return model_mem.exists(a) ? model_mem[a] : img_word(a);
  endfunction

  function automatic word_t merge_bytes(word_t old, word_t wdata, strb_t strb);
    word_t res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[b*8 +: 8] = wdata[b*8 +: 8];
    end
    return res;
  endfunction

  function automatic word_t mk_addr(int t, int i, int w);
    return {tag_pool[t], idx_pool[i], 2'(w), 2'b00};
  endfunction

  task automatic check_word(input string name, input word_t exp, input word_t act);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("ERR %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_line(input string name, input word_t exp_addr, input word_t act_addr,
                            input line_t exp, input line_t act);
    check_cnt++;
    if (act_addr !== exp_addr || act !== exp) begin
      err_cnt++;
      $display("ERR %s expected %h @%h actual %h @%h", name, exp, exp_addr, act, act_addr);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("ERR %s expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic abort_run(input string what);
    $display("timeout: %s", what);
    $display("CHECKS FAILED");
    $finish;
  endtask

  task automatic push_req(input logic op, input word_t addr, input word_t wdata,
                          input strb_t strb, input bit fast);
    cpu_req_t r;
    r.op    = op;
    r.addr  = addr;
    r.wdata = wdata;
    r.strb  = strb;
    stim_q.push_back(r);
    fast_q.push_back(fast);
  endtask

  // issues queued requests back to back and checks every answer
  task automatic run_batch(input string name);
    cpu_req_t cur;
    bit       cur_fast;
    bit       have;
    bit       last_fast;
    int       last_acc;
    int       idle;
    int       total;
    int       n_done;
    word_t    a;
    total     = stim_q.size();
    n_done    = 0;
    have      = 0;
    last_fast = 0;
    last_acc  = 0;
    idle      = 0;
    while (n_done < total) begin
      @(posedge clk);
      if (!have && stim_q.size() > 0) begin
        cur      = stim_q.pop_front();
        cur_fast = fast_q.pop_front();
        have     = 1;
      end
      valid <= have;
      req   <= cur;
      @(negedge clk);
      idle++;
      if (data_ok) begin
        if (pend_addr.size() == 0) begin
          err_cnt++;
          $display("%s: data_ok with no request outstanding", name);
        end else begin
          if (!pend_op[0]) begin
            check_word($sformatf("%s read %h", name, pend_addr[0]), pend_exp[0], rdata);
          end
          if (pend_fast[0]) begin
            check_word({name, " hit latency"}, 1, word_t'(cycle - pend_cyc[0]));
          end
          void'(pend_addr.pop_front());
          void'(pend_op.pop_front());
          void'(pend_exp.pop_front());
          void'(pend_cyc.pop_front());
          void'(pend_fast.pop_front());
          n_done++;
          idle = 0;
        end
      end
      if (have && addr_ok) begin
        a = {cur.addr[31:2], 2'b00};
        if (cur_fast && last_fast) begin
          check_word({name, " accept gap"}, 1, word_t'(cycle - last_acc));
        end
        last_fast = cur_fast;
        last_acc  = cycle;
        pend_addr.push_back(a);
        pend_op.push_back(cur.op);
        pend_exp.push_back(model_word(a));
        pend_cyc.push_back(cycle);
        pend_fast.push_back(cur_fast);
        if (cur.op) begin
          model_mem[a] = merge_bytes(model_word(a), cur.wdata, cur.strb);
          dirty_tb[{a[31:4], 4'h0}] = 1;
        end
        have = 0;
        idle = 0;
      end
      if (idle > TIMEOUT) abort_run({name, ": no accept or data_ok from the cache"});
    end
    @(posedge clk);
    valid <= 1'b0;
  endtask

  task automatic report_test(input string name, input int err_before);
    test_cnt++;
    if (err_cnt == err_before) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, err_cnt - err_before);
  endtask

  always @(posedge clk) cycle++;

  // memory side with random grant delays and beat gaps
  initial begin : mem_responder
    logic  wr_armed;
    logic  rd_armed;
    logic  beating;
    logic  wr_rdy_n;
    logic  rd_rdy_n;
    logic  ret_v_n;
    int    wr_wait;
    int    rd_wait;
    int    gap;
    int    beat;
    word_t line_addr;
    word_t wb_addr;
    line_t exp_line;
    wr_armed  = 0;
    rd_armed  = 0;
    beating   = 0;
    wr_wait   = 0;
    rd_wait   = 0;
    gap       = 0;
    beat      = 0;
    line_addr = '0;
    rd_rdy    = 1'b0;
    wr_rdy    = 1'b0;
    ret_valid = 1'b0;
    ret       = '0;
    forever begin
      @(negedge clk);
      wr_rdy_n = 1'b0;
      rd_rdy_n = 1'b0;
      if (wr_req && wr_rdy) begin
        wb_addr = {wr.addr[31:4], 4'h0};
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
          exp_line[w] = model_word(wb_addr + 4 * w);
        end
        check_line("write-back", wb_addr, wr.addr, exp_line, wr.data);
        check_flag("write-back of stored line", 1'b1, dirty_tb.exists(wb_addr));
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
          img_mem[wb_addr + 4 * w] = wr.data[w];
        end
        dirty_tb.delete(wb_addr);
        wb_cnt++;
        wr_armed = 0;
      end else if (wr_req) begin
        if (!wr_armed) begin
          wr_wait  = $random(seed) & 3;
          wr_armed = 1;
        end
        if (wr_wait == 0) wr_rdy_n = 1'b1;
        else wr_wait--;
      end
      if (ret_valid) begin
        beat++;
        if (beat == WORDS_PER_LINE) beating = 0;
        else gap = $random(seed) & 3;
      end
      if (rd_req && rd_rdy) begin
        line_addr = rd.addr;
        if (pend_addr.size() > 0) begin
          check_word("line read address", {pend_addr[0][31:4], 4'h0}, rd.addr);
        end
        rd_cnt++;
        rd_armed = 0;
        beating  = 1;
        beat     = 0;
        gap      = $random(seed) & 3;
      end else if (rd_req) begin
        if (!rd_armed) begin
          rd_wait  = $random(seed) & 3;
          rd_armed = 1;
        end
        if (rd_wait == 0) rd_rdy_n = 1'b1;
        else rd_wait--;
      end
      ret_v_n = 1'b0;
      if (beating) begin
        if (gap == 0) ret_v_n = 1'b1;
        else gap--;
      end
      @(posedge clk);
      wr_rdy    <= wr_rdy_n;
      rd_rdy    <= rd_rdy_n;
      ret_valid <= ret_v_n;
      ret.data  <= img_word(line_addr + 4 * beat);
      ret.last  <= (beat == WORDS_PER_LINE - 1);
    end
  end

  initial begin : main
    int    e0;
    int    wait_cnt;
    int    rd_before;
    int    t;
    int    i;
    int    w;
    word_t a;
    seed      = 47;
    cycle     = 0;
    err_cnt   = 0;
    check_cnt = 0;
    test_cnt  = 0;
    rd_cnt    = 0;
    wb_cnt    = 0;
    valid     = 1'b0;
    req       = '0;

    // outputs stay quiet during reset and one cycle after
    e0       = err_cnt;
    wait_cnt = 0;
    do begin
      @(negedge clk);
      check_flag("data_ok in reset", 1'b0, data_ok);
      check_flag("rd_req in reset", 1'b0, rd_req);
      check_flag("wr_req in reset", 1'b0, wr_req);
      check_flag("addr_ok in reset", 1'b0, addr_ok);
      wait_cnt++;
      if (wait_cnt > 20) abort_run("reset never released");
    end while (!resetn);
    check_flag("data_ok after reset", 1'b0, data_ok);
    check_flag("rd_req after reset", 1'b0, rd_req);
    check_flag("wr_req after reset", 1'b0, wr_req);
    report_test("reset", e0);

    // cold read fetches one line from the image
    e0        = err_cnt;
    rd_before = rd_cnt;
    push_req(1'b0, mk_addr(0, 0, 2), '0, '0, 0);
    run_batch("cold_read");
    check_word("cold read line fetches", 1, word_t'(rd_cnt - rd_before));
    report_test("cold_read", e0);

    // prime three sets then hit them back to back
    e0 = err_cnt;
    for (i = 0; i < 3; i++) push_req(1'b0, mk_addr(1, i, 0), '0, '0, 0);
    run_batch("prime");
    for (i = 0; i < 3; i++) push_req(1'b0, mk_addr(1, i, i + 1), '0, '0, 1);
    run_batch("hit_burst");
    report_test("hit_burst", e0);

    // store miss then store hit with a read after each
    e0 = err_cnt;
    a  = mk_addr(2, 0, 1);
    push_req(1'b1, a, 32'hdead_beef, 4'b0101, 0);
    push_req(1'b0, a, '0, '0, 0);
    push_req(1'b1, a, 32'h1234_5678, 4'b1100, 0);
    push_req(1'b0, a, '0, '0, 0);
    run_batch("store_merge");
    report_test("store_merge", e0);

    // random mix over the pool and a final sweep
    e0 = err_cnt;
    for (int n = 0; n < 300; n++) begin
      t = ($random(seed) & 32'h7fff_ffff) % 6;
      i = ($random(seed) & 32'h7fff_ffff) % 3;
      w = $random(seed) & 3;
      push_req($random(seed) & 1, mk_addr(t, i, w), $random(seed), $random(seed) & 4'hf, 0);
    end
    run_batch("random_mix");
    for (t = 0; t < 6; t++) begin
      for (i = 0; i < 3; i++) begin
        for (w = 0; w < 4; w++) push_req(1'b0, mk_addr(t, i, w), '0, '0, 0);
      end
    end
    run_batch("sweep");
    if (wb_cnt == 0) begin
      err_cnt++;
      $display("random_mix: no write-back was ever issued");
    end
    report_test("random_mix", e0);

    $display("tests %0d, checks %0d, errors %0d, write-backs %0d",
             test_cnt, check_cnt, err_cnt, wb_cnt);
    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- verilog/cache_ctrl_fsm.sv
`timescale 1ns/1ps

module cache_ctrl_fsm (
  input  logic             clk,
  input  logic             resetn,
  input  logic             valid_i,
  input  logic             hit_i,
  input  logic             store_op_i,
  input  logic             victim_dirty_i,
  input  logic             rd_rdy_i,
  input  logic             wr_rdy_i,
  input  logic             ret_valid_i,
  input  logic             ret_last_i,
  output logic             addr_ok_o,
  output logic             data_ok_o,
  output logic             rd_req_o,
  output logic             wr_req_o,
  output cache_pkg::ctrl_t ctrl_o,
  output logic             beat_en_o,
  output logic             clear_o
);

  import cache_pkg::*;

  cache_state_t state_q;
  cache_state_t state_d;
  logic         ready_q;  // set from the first cycle after reset

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state_q <= IDLE;
      ready_q <= 1'b0;
    end else begin
      state_q <= state_d;
      ready_q <= 1'b1;
    end
  end

  always_comb begin
    state_d   = state_q;
    addr_ok_o = 1'b0;
    data_ok_o = 1'b0;
    rd_req_o  = 1'b0;
    wr_req_o  = 1'b0;
    beat_en_o = 1'b0;
    clear_o   = 1'b0;
    ctrl_o    = '0;

    case (state_q)
      IDLE: begin
        addr_ok_o = ready_q;
        if (valid_i && ready_q) begin
          ctrl_o.accept = 1'b1;
          state_d       = LOOKUP;
        end
      end

      LOOKUP: begin
        if (hit_i) begin
          data_ok_o = 1'b1;
          if (store_op_i) begin
            state_d = WRITE;  // array write next cycle
          end else begin
            // read hit overlaps with the next request
            addr_ok_o     = 1'b1;
            ctrl_o.accept = valid_i;
            state_d       = valid_i ? LOOKUP : IDLE;
          end
        end else begin
          state_d = MISS;
        end
      end

      WRITE: begin
        ctrl_o.store_write = 1'b1;
        state_d            = IDLE;
      end

      MISS: begin
        ctrl_o.victim_load = 1'b1;
        state_d            = victim_dirty_i ? WRITEBACK : REPLACE;
      end

      WRITEBACK: begin
        wr_req_o = 1'b1;  // held until accepted
        if (wr_rdy_i) begin
          state_d = REPLACE;
        end
      end

      REPLACE: begin
        rd_req_o = 1'b1;
        clear_o  = 1'b1;  // fresh beat count for this refill
        if (rd_rdy_i) begin
          state_d = REFILL;
        end
      end

      REFILL: begin
        beat_en_o = ret_valid_i;
        if (ret_valid_i && ret_last_i) begin
          // install and answer on the last beat
          ctrl_o.refill_write  = 1'b1;
          ctrl_o.rd_sel_refill = 1'b1;
          data_ok_o            = 1'b1;
          state_d              = IDLE;
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

endmodule

//--- verilog/cache_pkg.sv
package cache_pkg;

  // geometry, two ways of 4 KB each
  localparam int ADDR_W         = 32;
  localparam int WORD_W         = 32;
  localparam int OFFSET_W       = 4;
  localparam int INDEX_W        = 8;
  localparam int TAG_W          = ADDR_W - INDEX_W - OFFSET_W;  // 20
  localparam int WORDS_PER_LINE = 4;
  localparam int NUM_WAYS       = 2;

  typedef logic [TAG_W-1:0]    tag_t;
  typedef logic [INDEX_W-1:0]  index_t;
  typedef logic [OFFSET_W-1:0] offset_t;
  typedef logic [WORD_W-1:0]   word_t;
  typedef logic [WORD_W/8-1:0] strb_t;

  // word 0 sits in the low bits
  typedef logic [WORDS_PER_LINE-1:0][WORD_W-1:0] line_t;

  typedef struct packed {
    tag_t    tag;
    index_t  index;
    offset_t offset;
  } addr_t;

  typedef struct packed {
    logic valid;
    logic dirty;
    tag_t tag;
  } tag_entry_t;

  typedef struct packed {
    logic  op;     // 1 for a store
    addr_t addr;
    word_t wdata;
    strb_t strb;
  } cpu_req_t;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    WRITE,
    MISS,
    WRITEBACK,
    REPLACE,
    REFILL
  } cache_state_t;

  // datapath steering from the controller
  typedef struct packed {
    logic accept;         // load request buffer
    logic store_write;    // merge store into hit way
    logic victim_load;    // capture victim way and tag
    logic refill_write;   // install refilled line
    logic rd_sel_refill;  // rdata from refill line
  } ctrl_t;

endpackage

//--- verilog/dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
  input  logic                     clk,
  input  logic                     resetn,
  // cpu side
  input  logic                     valid_i,
  input  cache_pkg::cpu_req_t      req_i,
  output logic                     addr_ok_o,
  output logic                     data_ok_o,
  output cache_pkg::word_t         rdata_o,
  // memory read channel
  output logic                     rd_req_o,
  output mem_bus_pkg::mem_rd_req_t rd_o,
  input  logic                     rd_rdy_i,
  input  logic                     ret_valid_i,
  input  mem_bus_pkg::mem_ret_t    ret_i,
  // memory write channel
  output logic                     wr_req_o,
  output mem_bus_pkg::mem_wr_req_t wr_o,
  input  logic                     wr_rdy_i
);

  import cache_pkg::*;

  ctrl_t ctrl;
  logic  hit;
  logic  store_op;
  logic  victim_dirty;
  logic  beat_en;
  logic  clear;
  logic  victim_way;
  line_t refill_line;

  cache_ctrl_fsm u_fsm (
    .clk            (clk),
    .resetn         (resetn),
    .valid_i        (valid_i),
    .hit_i          (hit),
    .store_op_i     (store_op),
    .victim_dirty_i (victim_dirty),
    .rd_rdy_i       (rd_rdy_i),
    .wr_rdy_i       (wr_rdy_i),
    .ret_valid_i    (ret_valid_i),
    .ret_last_i     (ret_i.last),
    .addr_ok_o      (addr_ok_o),
    .data_ok_o      (data_ok_o),
    .rd_req_o       (rd_req_o),
    .wr_req_o       (wr_req_o),
    .ctrl_o         (ctrl),
    .beat_en_o      (beat_en),
    .clear_o        (clear)
  );

  refill_counter u_refill (
    .clk          (clk),
    .resetn       (resetn),
    .beat_en_i    (beat_en),
    .clear_i      (clear),
    .beat_i       (ret_i.data),
    .line_o       (refill_line),
    .victim_way_o (victim_way)
  );

  lookup_datapath u_datapath (
    .clk            (clk),
    .resetn         (resetn),
    .req_i          (req_i),
    .ctrl_i         (ctrl),
    .victim_way_i   (victim_way),
    .refill_line_i  (refill_line),
    .refill_word_i  (ret_i.data),  // last beat goes straight in
    .hit_o          (hit),
    .store_op_o     (store_op),
    .victim_dirty_o (victim_dirty),
    .rdata_o        (rdata_o),
    .rd_o           (rd_o),
    .wr_o           (wr_o)
  );

endmodule

//--- verilog/lookup_datapath.sv
`timescale 1ns/1ps

module lookup_datapath (
  input  logic                     clk,
  input  logic                     resetn,
  input  cache_pkg::cpu_req_t      req_i,
  input  cache_pkg::ctrl_t         ctrl_i,
  input  logic                     victim_way_i,
  input  cache_pkg::line_t         refill_line_i,
  input  cache_pkg::word_t         refill_word_i,
  output logic                     hit_o,
  output logic                     store_op_o,
  output logic                     victim_dirty_o,
  output cache_pkg::word_t         rdata_o,
  output mem_bus_pkg::mem_rd_req_t rd_o,
  output mem_bus_pkg::mem_wr_req_t wr_o
);

  import cache_pkg::*;

  localparam int SETS   = 1 << INDEX_W;
  localparam int WIDX_W = OFFSET_W - 2;

  cpu_req_t                       req_q;     // request buffer
  index_t                         ram_addr;
  logic [WIDX_W-1:0]              word_idx;
  logic [NUM_WAYS-1:0][SETS-1:0]  valid_q;
  tag_entry_t                     tag_rd [NUM_WAYS];
  line_t                          line_rd [NUM_WAYS];
  logic [NUM_WAYS-1:0]            hit_way;
  logic [NUM_WAYS-1:0]            ram_we;
  logic                           hit_sel;
  logic                           victim_way_q;
  tag_t                           victim_tag_q;
  line_t                          hit_line;
  line_t                          install_line;
  line_t                          base_line;
  line_t                          line_wdata;
  tag_entry_t                     tag_wdata;

  // byte-wise store merge into one word of a line
  function automatic line_t merge_store(line_t line, logic [WIDX_W-1:0] widx,
                                        word_t wdata, strb_t strb);
    line_t merged;
    int    b;
    merged = line;
    for (b = 0; b < WORD_W / 8; b++) begin
      if (strb[b]) begin
        merged[widx][b*8 +: 8] = wdata[b*8 +: 8];
      end
    end
    return merged;
  endfunction

  always_ff @(posedge clk) begin
    if (ctrl_i.accept) begin
      req_q <= req_i;
    end
  end

  // incoming index on accept, buffered one otherwise
  assign ram_addr = ctrl_i.accept ? req_i.addr.index : req_q.addr.index;
  assign word_idx = req_q.addr.offset[OFFSET_W-1:2];

  for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
    assign hit_way[w] = valid_q[w][req_q.addr.index] &&
                        (tag_rd[w].tag == req_q.addr.tag);
    assign ram_we[w]  = (ctrl_i.store_write && hit_way[w]) ||
                        (ctrl_i.refill_write && (victim_way_q == 1'(w)));

    sync_ram #(
      .DEPTH_W (INDEX_W),
      .entry_t (tag_entry_t)
    ) u_tag_ram (
      .clk     (clk),
      .en_i    (ctrl_i.accept | ram_we[w]),
      .we_i    (ram_we[w]),
      .addr_i  (ram_addr),
      .wdata_i (tag_wdata),
      .rdata_o (tag_rd[w])
    );

    sync_ram #(
      .DEPTH_W (INDEX_W),
      .entry_t (line_t)
    ) u_line_ram (
      .clk     (clk),
      .en_i    (ctrl_i.accept | ram_we[w]),
      .we_i    (ram_we[w]),
      .addr_i  (ram_addr),
      .wdata_i (line_wdata),
      .rdata_o (line_rd[w])
    );
  end

  assign hit_o      = |hit_way;
  assign hit_sel    = hit_way[1];
  assign store_op_o = req_q.op;
  assign hit_line   = line_rd[hit_sel];

  // only meaningful in MISS, against the live toggle
  assign victim_dirty_o = valid_q[victim_way_i][req_q.addr.index] &&
                          tag_rd[victim_way_i].dirty;

  always_ff @(posedge clk) begin
    if (ctrl_i.victim_load) begin
      victim_way_q <= victim_way_i;
      victim_tag_q <= tag_rd[victim_way_i].tag;
    end
  end

  // last beat is still on the bus, not yet in the counter register
  always_comb begin
    install_line = refill_line_i;
    install_line[WORDS_PER_LINE-1] = refill_word_i;
  end

  always_comb begin
    base_line = ctrl_i.store_write ? hit_line : install_line;
    line_wdata = req_q.op ? merge_store(base_line, word_idx, req_q.wdata, req_q.strb)
                          : base_line;
    tag_wdata.valid = 1'b1;
    tag_wdata.dirty = req_q.op;  // store hit or store miss leaves it dirty
    tag_wdata.tag   = req_q.addr.tag;
  end

  assign rdata_o = ctrl_i.rd_sel_refill ? install_line[word_idx] : hit_line[word_idx];

  always_ff @(posedge clk) begin
    if (!resetn) begin
      valid_q <= '0;
    end else if (ctrl_i.refill_write) begin
      valid_q[victim_way_q][req_q.addr.index] <= 1'b1;
    end
  end

  // line-aligned memory addresses
  assign rd_o.addr = {req_q.addr.tag, req_q.addr.index, {OFFSET_W{1'b0}}};
  assign wr_o.addr = {victim_tag_q, req_q.addr.index, {OFFSET_W{1'b0}}};
  assign wr_o.data = line_rd[victim_way_q];  // array output held since lookup

endmodule

//--- verilog/mem_bus_pkg.sv
package mem_bus_pkg;

  // line read request, offset bits always zero
  typedef struct packed {
    logic [cache_pkg::ADDR_W-1:0] addr;
  } mem_rd_req_t;

  // write-back of a dirty victim line
  typedef struct packed {
    logic [cache_pkg::ADDR_W-1:0] addr;
    cache_pkg::line_t             data;
  } mem_wr_req_t;

  // one return beat
  typedef struct packed {
    cache_pkg::word_t data;
    logic             last;  // set on the fourth beat
  } mem_ret_t;

endpackage

//--- verilog/refill_counter.sv
`timescale 1ns/1ps

module refill_counter (
  input  logic             clk,
  input  logic             resetn,
  input  logic             beat_en_i,
  input  logic             clear_i,
  input  cache_pkg::word_t beat_i,
  output cache_pkg::line_t line_o,
  output logic             victim_way_o
);

  import cache_pkg::*;

  localparam int CNT_W = $clog2(WORDS_PER_LINE);

  logic [CNT_W-1:0] beat_cnt;
  line_t            line_q;
  logic             way_q;

  // beat position within the line
  always_ff @(posedge clk) begin
    if (!resetn) begin
      beat_cnt <= '0;
    end else if (clear_i) begin
      beat_cnt <= '0;
    end else if (beat_en_i) begin
      beat_cnt <= beat_cnt + 1'b1;
    end
  end

  // beats arrive in word order
  always_ff @(posedge clk) begin
    if (beat_en_i) begin
      line_q[beat_cnt] <= beat_i;
    end
  end

  // free-running toggle stands in for a random victim pick
  always_ff @(posedge clk) begin
    if (!resetn) begin
      way_q <= 1'b0;
    end else begin
      way_q <= ~way_q;
    end
  end

  assign line_o       = line_q;
  assign victim_way_o = way_q;

endmodule

//--- verilog/sync_ram.sv
`timescale 1ns/1ps

module sync_ram #(
  parameter int  DEPTH_W = 8,
  parameter type entry_t = logic
) (
  input  logic               clk,
  input  logic               en_i,
  input  logic               we_i,
  input  logic [DEPTH_W-1:0] addr_i,
  input  entry_t             wdata_i,
  output entry_t             rdata_o
);

  localparam int DEPTH = 1 << DEPTH_W;

  entry_t mem [DEPTH];

  // single port, read-first
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        mem[addr_i] <= wdata_i;
      end
      rdata_o <= mem[addr_i];  // holds while en_i is low
    end
  end

endmodule
